// File: hdl/hamming_macros.svh
//------------------------------
// hamming codec macros
// code size and tag width
//------------------------------
`ifndef HAMMING_MACROS_SVH
`define HAMMING_MACROS_SVH

//------------------------------
// code selection
//------------------------------
// parity bit count, 3..6
`define HAMMING_R 4

// 1 adds the overall parity bit (secded), 0 gives plain hamming
`define HAMMING_EXT 1

//------------------------------
// stream side
//------------------------------
`define HAMMING_TAG_W 4 // default tag width

`endif

// File: hdl/hamming_code_pkg.sv
//------------------------------
// hamming code package
// geometry constants, classic position map,
// syndrome helpers and decoder status
//------------------------------
`include "hamming_macros.svh"

package hamming_code_pkg;

  //------------------------------
  // code geometry
  //------------------------------
  localparam int c_cbits = (1 << `HAMMING_R) - 1;               // base word
  localparam int c_dbits = c_cbits - `HAMMING_R;                 // data part
  localparam int c_nbits = c_cbits + ((`HAMMING_EXT != 0) ? 1 : 0); // on the line

  typedef logic [`HAMMING_R-1:0] syndrome_t;

  // decoder result flags, both low on a clean word
  typedef struct packed {
    logic daterr;  // error seen and corrected
    logic decfail; // uncorrectable, two bit error
  } dec_status_t;

  //------------------------------
  // position map
  //------------------------------
  // i-th non power of two position, counting from 1
  function automatic int data_pos(input int i);
    int cnt;
    int pos;
    cnt = 0;
    pos = 0;
    for (int p = 3; p <= c_cbits; p++) begin
      if ((p & (p - 1)) != 0) begin // skip parity slots
        if (cnt == i) begin
          pos = p;
        end
        cnt++;
      end
    end
    return pos;
  endfunction

  // transmission index -> classic position
  // data first, then parity j at 2^j
  function automatic int tx_pos(input int idx);
    if (idx < c_dbits) begin
      return data_pos(idx);
    end
    return 1 << (idx - c_dbits);
  endfunction

  //------------------------------
  // syndrome
  //------------------------------
  // xor of positions of all set bits, word in transmission order
  function automatic syndrome_t word_syndrome(input logic [c_cbits-1:0] w);
    syndrome_t syn;
    syn = '0;
    for (int idx = 0; idx < c_cbits; idx++) begin
      if (w[idx]) begin
        syn = syn ^ syndrome_t'(tx_pos(idx));
      end
    end
    return syn;
  endfunction

endpackage

// File: hdl/hamming_stream_pkg.sv
//------------------------------
// hamming stream package
// serial strobe bundle and default tag
//------------------------------
`include "hamming_macros.svh"

package hamming_stream_pkg;

  //------------------------------
  // one bit per valid cycle
  //------------------------------
  typedef struct packed {
    logic sop; // first bit of frame
    logic val; // dat is valid
    logic eop; // last bit of frame
    logic dat; // payload bit
  } bit_strobe_t;

  //------------------------------
  // frame tag
  //------------------------------
  // carried from sop through to the output frame
  typedef logic [`HAMMING_TAG_W-1:0] tag_t;

endpackage

// File: hdl/hamming_enc.sv
`timescale 1ns/1ps
//------------------------------
// hamming encoder
// serial systematic encoder, data bits pass
// through and parity + overall bit follow eop
//------------------------------
module hamming_enc #(
  parameter type tag_t = hamming_stream_pkg::tag_t
) (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iclkena,
  input  hamming_stream_pkg::bit_strobe_t in_strobe,
  input  tag_t                            in_tag,
  output hamming_stream_pkg::bit_strobe_t out_strobe,
  output tag_t                            out_tag
);

  localparam int c_dbits = hamming_code_pkg::c_dbits;
  localparam int c_pbits = hamming_code_pkg::c_nbits - c_dbits; // appended bits
  localparam int c_dcw   = $clog2(c_dbits);
  localparam int c_pcw   = $clog2(c_pbits);

  logic                          busy;    // shifting parity out
  logic [c_pcw-1:0]              pcnt;    // parity bit index
  logic [c_dcw-1:0]              dcnt;    // next data index
  logic [c_dcw-1:0]              didx;    // index of current bit
  hamming_code_pkg::syndrome_t   par;     // parity accumulator
  hamming_code_pkg::syndrome_t   par_nxt;
  logic                          dx;      // xor of data so far
  logic                          dx_nxt;
  logic                          ext_nxt; // overall parity of base word
  logic [c_pbits-1:0]            psr;     // parity shift reg, lsb out first
  logic                          take;

  assign take = in_strobe.val & ~busy; // input dropped during parity tail

  //------------------------------
  // parity accumulate
  //------------------------------
  always_comb begin
    didx    = in_strobe.sop ? '0 : dcnt;   // sop restarts the frame
    par_nxt = in_strobe.sop ? '0 : par;
    dx_nxt  = in_strobe.sop ? 1'b0 : dx;
    if (in_strobe.dat) begin
      // parity j sees the bit if its position has bit j set
      par_nxt = par_nxt ^ hamming_code_pkg::syndrome_t'(
                  hamming_code_pkg::data_pos(int'(didx)));
      dx_nxt  = ~dx_nxt;
    end
    ext_nxt = dx_nxt ^ (^par_nxt); // data xor parity
  end

  // payload side, no reset
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (take) begin
        dcnt <= didx + 1'b1;
        par  <= par_nxt;
        dx   <= dx_nxt;
        if (in_strobe.sop) begin
          out_tag <= in_tag;
        end
        if (in_strobe.eop) begin
          // ext bit lands in msb, dropped when plain code
          psr <= c_pbits'({ext_nxt, par_nxt});
        end
      end
      else if (busy) begin
        psr <= psr >> 1;
      end
    end
  end

  //------------------------------
  // output strobe
  //------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_strobe <= '0;
      busy       <= 1'b0;
      pcnt       <= '0;
    end
    else if (iclkena) begin
      out_strobe <= '0; // idle unless driven below
      if (busy) begin
        out_strobe.val <= 1'b1;
        out_strobe.dat <= psr[0];
        out_strobe.eop <= (pcnt == c_pcw'(c_pbits - 1)); // final appended bit
        pcnt           <= pcnt + 1'b1;
        busy           <= (pcnt != c_pcw'(c_pbits - 1));
      end
      else if (in_strobe.val) begin
        out_strobe.val <= 1'b1;          // data passes straight through
        out_strobe.sop <= in_strobe.sop;
        out_strobe.dat <= in_strobe.dat;
        if (in_strobe.eop) begin
          busy <= 1'b1;                  // parity follows with no gap
          pcnt <= '0;
        end
      end
    end
  end

endmodule

// File: hdl/hamming_dec.sv
`timescale 1ns/1ps
//------------------------------
// hamming decoder
// serial secded decoder, corrects one error,
// flags two, streams data out of a buffer
//------------------------------
`include "hamming_macros.svh"

module hamming_dec #(
  parameter type tag_t = hamming_stream_pkg::tag_t
) (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iclkena,
  input  hamming_stream_pkg::bit_strobe_t in_strobe,
  input  tag_t                            in_tag,
  output hamming_stream_pkg::bit_strobe_t out_strobe,
  output tag_t                            out_tag,
  output hamming_code_pkg::dec_status_t   out_status
);

  localparam int c_cbits = hamming_code_pkg::c_cbits;
  localparam int c_dbits = hamming_code_pkg::c_dbits;
  localparam int c_dcw   = $clog2(c_dbits);

  //------------------------------
  // frame assembly
  //------------------------------
  logic [c_cbits-1:0] word;    // base word, word[0] = first bit sent
  logic               edat;    // last bit seen, ext bit at frame end
  logic               eop_r;   // frame complete in word
  tag_t               tag_r;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      eop_r <= 1'b0;
    end
    else if (iclkena) begin
      eop_r <= in_strobe.val & in_strobe.eop;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && in_strobe.val) begin
      edat <= in_strobe.dat;
      // extended mode keeps one bit back so the ext bit stays out of word
      word <= (`HAMMING_EXT != 0) ? {edat, word[c_cbits-1:1]}
                                  : {in_strobe.dat, word[c_cbits-1:1]};
      if (in_strobe.sop) begin
        tag_r <= in_tag;
      end
    end
  end

  //------------------------------
  // decode
  //------------------------------
  hamming_code_pkg::syndrome_t   syn;
  logic                          par_fail; // overall parity broken
  logic [c_cbits-1:0]            fix;
  hamming_code_pkg::dec_status_t status;

  always_comb begin
    syn      = hamming_code_pkg::word_syndrome(word);
    par_fail = (^word) ^ edat;
    fix      = word;
    // syndrome names the bad position, zero matches nothing
    for (int i = 0; i < c_cbits; i++) begin
      if (hamming_code_pkg::tx_pos(i) == int'(syn)) begin
        fix[i] = ~fix[i];
      end
    end
    if (`HAMMING_EXT != 0) begin
      status.daterr  = par_fail;                  // odd count, 1 error
      status.decfail = (syn != '0) & ~par_fail;   // even count, 2 errors
    end
    else begin
      status.daterr  = (syn != '0);
      status.decfail = 1'b0;                      // no way to tell
    end
  end

  //------------------------------
  // serial output
  //------------------------------
  logic               osop;
  logic               oval;
  logic               oeop;
  logic [c_dcw-1:0]   ocnt;  // bits left after current
  logic [c_dbits-1:0] obuf;  // corrected data, lsb on the line

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      osop <= 1'b0;
      oval <= 1'b0;
      oeop <= 1'b0;
      ocnt <= '0;
    end
    else if (iclkena) begin
      if (eop_r) begin
        osop <= 1'b1;
        oval <= 1'b1;
        oeop <= 1'b0;
        ocnt <= c_dcw'(c_dbits - 1);
      end
      else if (oval) begin
        osop <= 1'b0;
        oval <= (ocnt != '0);
        oeop <= (ocnt == c_dcw'(1)); // next bit is the last
        ocnt <= ocnt - 1'b1;
      end
    end
  end

  // buffer, tag and flags load together, held for the frame
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (eop_r) begin
        obuf       <= fix[c_dbits-1:0];
        out_tag    <= tag_r;
        out_status <= status;
      end
      else if (oval) begin
        obuf <= obuf >> 1;
      end
    end
  end

  assign out_strobe = '{sop: osop, val: oval, eop: oeop, dat: obuf[0]};

endmodule

// File: hdl/hamming_codec.sv
`timescale 1ns/1ps
//------------------------------
// hamming codec top
// independent encoder and decoder paths
//------------------------------
module hamming_codec #(
  parameter type tag_t = hamming_stream_pkg::tag_t
) (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iclkena,
  // encoder path
  input  hamming_stream_pkg::bit_strobe_t enc_in,
  input  tag_t                            enc_in_tag,
  output hamming_stream_pkg::bit_strobe_t enc_out,
  output tag_t                            enc_out_tag,
  // decoder path
  input  hamming_stream_pkg::bit_strobe_t dec_in,
  input  tag_t                            dec_in_tag,
  output hamming_stream_pkg::bit_strobe_t dec_out,
  output tag_t                            dec_out_tag,
  output hamming_code_pkg::dec_status_t   dec_status
);

  hamming_enc #(.tag_t(tag_t)) enc0 (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .in_strobe  (enc_in),
    .in_tag     (enc_in_tag),
    .out_strobe (enc_out),
    .out_tag    (enc_out_tag)
  );

  // channel between the two is outside the codec
  hamming_dec #(.tag_t(tag_t)) dec0 (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .in_strobe  (dec_in),
    .in_tag     (dec_in_tag),
    .out_strobe (dec_out),
    .out_tag    (dec_out_tag),
    .out_status (dec_status)
  );

endmodule

// File: tests/hamming_checker.sv
`timescale 1ns/1ps
//------------------------------
// hamming codec checker
// stream framing and status flag assertions
//------------------------------
module hamming_checker (
  input logic                            iclk,
  input logic                            ireset,
  input logic                            iclkena,
  input hamming_stream_pkg::bit_strobe_t enc_out,
  input hamming_stream_pkg::bit_strobe_t dec_out,
  input hamming_code_pkg::dec_status_t   dec_status
);

  localparam int c_dbits = hamming_code_pkg::c_dbits;
  localparam int c_nbits = hamming_code_pkg::c_nbits;

  int enc_cnt;           // bits seen before current
  int dec_cnt;
  int assert_fails = 0;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      enc_cnt <= 0;
      dec_cnt <= 0;
    end
    else if (iclkena) begin
      if (enc_out.val) enc_cnt <= enc_out.eop ? 0 : (enc_out.sop ? 1 : enc_cnt + 1);
      if (dec_out.val) dec_cnt <= dec_out.eop ? 0 : (dec_out.sop ? 1 : dec_cnt + 1);
    end
  end

  //------------------------------
  // framing
  //------------------------------
  a_enc_len: assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && enc_out.val && enc_out.eop) |-> ((enc_out.sop ? 0 : enc_cnt) == c_nbits - 1))
    else begin
      assert_fails++;
      $error("encoder frame length wrong");
    end

  a_dec_len: assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && dec_out.val && dec_out.eop) |-> ((dec_out.sop ? 0 : dec_cnt) == c_dbits - 1))
    else begin
      assert_fails++;
      $error("decoder frame length wrong");
    end

  // no hole in decoder output before eop
  a_dec_run: assert property (@(posedge iclk) disable iff (ireset)
    (dec_out.val && !dec_out.eop) |=> dec_out.val)
    else begin
      assert_fails++;
      $error("decoder valid dropped inside frame");
    end

  a_dec_sop_val: assert property (@(posedge iclk) disable iff (ireset)
    dec_out.sop |-> dec_out.val)
    else begin
      assert_fails++;
      $error("decoder sop without valid");
    end

  a_enc_sop_val: assert property (@(posedge iclk) disable iff (ireset)
    enc_out.sop |-> enc_out.val)
    else begin
      assert_fails++;
      $error("encoder sop without valid");
    end

  a_flags: assert property (@(posedge iclk) disable iff (ireset)
    dec_out.val |-> !(dec_status.daterr && dec_status.decfail))
    else begin
      assert_fails++;
      $error("daterr and decfail both set");
    end

endmodule

// File: tests/hamming_tb.sv
`timescale 1ns/1ps
//------------------------------
// hamming codec testbench
// random frames through the encoder, 0/1/2 bit
// errors on the replay into the decoder
//------------------------------
`include "hamming_macros.svh"

module hamming_tb;

  localparam int  c_dbits  = hamming_code_pkg::c_dbits;
  localparam int  c_nbits  = hamming_code_pkg::c_nbits;
  localparam int  c_kinds  = (`HAMMING_EXT != 0) ? 3 : 2; // clean, single, double
  localparam int  c_frames = c_kinds * c_nbits;  // per path
  localparam int  c_gap    = 4;   // worst stretch from enable gaps
  localparam time c_period = 8ns;

  typedef hamming_stream_pkg::bit_strobe_t strobe_t;
  typedef hamming_stream_pkg::tag_t        tag_t;
  typedef hamming_code_pkg::dec_status_t   status_t;

  logic    iclk;
  logic    ireset;
  logic    iclkena;
  strobe_t enc_in;
  tag_t    enc_in_tag;
  strobe_t enc_out;
  tag_t    enc_out_tag;
  strobe_t dec_in;
  tag_t    dec_in_tag;
  strobe_t dec_out;
  tag_t    dec_out_tag;
  status_t dec_status;

  logic [31:0]        lfsr_state = 32'h0a86_6640;
  bit                 gaps_on;
  int                 check_cnt;
  int                 mismatch_cnt;
  int                 fail_cnt;
  int                 dec_frames;
  logic [c_dbits-1:0] orig_data [c_frames];
  tag_t               orig_tag  [c_frames];
  int                 dexp_nerr [c_frames];  // errors injected per frame
  logic [c_nbits-1:0] cw_q [$];              // captured codewords
  tag_t               ctag_q [$];

  hamming_codec dut0 (
    .iclk, .ireset, .iclkena,
    .enc_in, .enc_in_tag, .enc_out, .enc_out_tag,
    .dec_in, .dec_in_tag, .dec_out, .dec_out_tag, .dec_status
  );

  bind hamming_codec hamming_checker chk0 (
    .iclk(iclk), .ireset(ireset), .iclkena(iclkena),
    .enc_out(enc_out), .dec_out(dec_out), .dec_status(dec_status)
  );

  initial begin
    iclk = 1'b0;
    forever #(c_period / 2) iclk = ~iclk;
  end

  //------------------------------
  // lfsr and reference model
  //------------------------------
  // taps 32 22 2 1
  function automatic logic take_bit();
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    return lfsr_state[0];
  endfunction

  function automatic int take_bits(input int n);
    int r;
    r = 0;
    for (int k = 0; k < n; k++) begin
      r = (r << 1) | int'(take_bit());
    end
    return r;
  endfunction

  // i-th position above 2 that is no power of two
  function automatic int pos_of_data(input int i);
    int p;
    int cnt;
    p   = 2;
    cnt = -1;
    while (cnt < i) begin
      p++;
      if ((p & (p - 1)) != 0) cnt++;
    end
    return p;
  endfunction

  function automatic logic [c_nbits-1:0] encode_ref(input logic [c_dbits-1:0] d);
    logic [c_nbits-1:0] cw;
    int                 p;
    cw = '0;
    for (int i = 0; i < c_dbits; i++) begin
      cw[i] = d[i];
      p     = pos_of_data(i);
      for (int j = 0; j < `HAMMING_R; j++) begin
        if (d[i] && ((p >> j) & 1) != 0) cw[c_dbits + j] = ~cw[c_dbits + j];
      end
    end
    if (`HAMMING_EXT != 0) cw[c_nbits-1] = ^cw; // top bit still 0 here
    return cw;
  endfunction

  function automatic status_t predict_status(input int nerr);
    status_t s;
    s = '0;
    if (`HAMMING_EXT != 0) begin
      s.daterr  = (nerr == 1);
      s.decfail = (nerr == 2);
    end
    else begin
      s.daterr = (nerr != 0);
    end
    return s;
  endfunction

  //------------------------------
  // compare tasks
  //------------------------------
  task automatic check_word(input string name, input logic [c_nbits-1:0] exp,
                            input logic [c_nbits-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    check_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    check_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  // one enabled cycle, random disabled cycles in front when gaps_on
  task automatic drive_cycle(input strobe_t es, input tag_t et,
                             input strobe_t ds, input tag_t dt);
    bit en;
    do begin
      @(posedge iclk);
      en = !gaps_on || (take_bits(2) != 0);
      iclkena    <= en;
      enc_in     <= es;
      enc_in_tag <= et;
      dec_in     <= ds;
      dec_in_tag <= dt;
    end while (!en);
  endtask

  //------------------------------
  // stimulus
  //------------------------------
  initial begin : stimulus
    logic [c_dbits-1:0] d;
    logic [c_nbits-1:0] mask;
    tag_t               tg;
    int                 nerr;
    int                 p1;
    int                 p2;
    ireset     <= 1'b1;
    iclkena    <= 1'b0;
    enc_in     <= '0;
    enc_in_tag <= '0;
    dec_in     <= '0;
    dec_in_tag <= '0;
    gaps_on = 1'b0;
    repeat (3) @(posedge iclk);
    ireset  <= 1'b0;
    iclkena <= 1'b1;
    repeat (6) begin // quiet outputs before the first sop
      @(posedge iclk);
      if (enc_out.val | enc_out.sop | enc_out.eop | dec_out.val | dec_out.sop | dec_out.eop) begin
        $display("ERROR: stream output active between reset and first frame");
        fail_cnt++;
      end
    end
    gaps_on = 1'b1;
    // encoder frames, parity tail gap after each
    // tag only valid with sop, other cycles carry its inverse
    for (int f = 0; f < c_frames; f++) begin
      for (int i = 0; i < c_dbits; i++) d[i] = take_bit();
      for (int t = 0; t < $bits(tag_t); t++) tg[t] = take_bit();
      orig_data[f] = d;
      orig_tag[f]  = tg;
      for (int i = 0; i < c_dbits; i++) begin
        drive_cycle('{sop: (i == 0), val: 1'b1, eop: (i == c_dbits - 1), dat: d[i]},
                    (i == 0) ? tg : ~tg, '0, '0);
      end
      repeat (c_nbits - c_dbits + 1) drive_cycle('0, ~tg, '0, '0);
    end
    while (cw_q.size() < c_frames) drive_cycle('0, '0, '0, '0);
    // decoder frames back to back through the error channel
    for (int f = 0; f < c_frames; f++) begin
      nerr = f % c_kinds;
      mask = '0;
      // single errors walk every position, ext bit included
      p1   = (nerr == 1) ? (f / c_kinds) % c_nbits : take_bits(8) % c_nbits;
      if (nerr > 0) mask[p1] = 1'b1;
      if (nerr > 1) begin
        do p2 = take_bits(8) % c_nbits; while (p2 == p1);
        mask[p2] = 1'b1;
      end
      dexp_nerr[f] = nerr;
      for (int i = 0; i < c_nbits; i++) begin
        if (i > 0 && take_bits(3) == 0) drive_cycle('0, '0, '0, ~ctag_q[f]); // val gap
        drive_cycle('0, '0,
                    '{sop: (i == 0), val: 1'b1, eop: (i == c_nbits - 1),
                      dat: cw_q[f][i] ^ mask[i]},
                    (i == 0) ? ctag_q[f] : ~ctag_q[f]);
      end
    end
    while (dec_frames < c_frames) drive_cycle('0, '0, '0, '0);
    repeat (4) drive_cycle('0, '0, '0, '0);
    fail_cnt += dut0.chk0.assert_fails;
    $display("checks=%0d mismatches=%0d other errors=%0d", check_cnt, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end
    else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  //------------------------------
  // compare processes
  //------------------------------
  initial begin : enc_compare
    logic [c_nbits-1:0] cw;
    tag_t               tg;
    int                 idx;
    int                 f;
    cw  = '0;
    tg  = '0;
    idx = 0;
    f   = 0;
    forever begin
      @(posedge iclk);
      if (!ireset && iclkena && enc_out.val) begin
        if (enc_out.sop) begin
          idx = 0;
          tg  = enc_out_tag;
        end
        if (idx < c_nbits) cw[idx] = enc_out.dat;
        idx++;
        if (enc_out.eop) begin
          if (f >= c_frames) begin
            $display("ERROR: encoder sent more frames than were driven");
            fail_cnt++;
          end
          else begin
            check_word($sformatf("enc_word frame %0d", f), encode_ref(orig_data[f]), cw);
            check_tag($sformatf("enc_tag frame %0d", f), orig_tag[f], tg);
            cw_q.push_back(cw);
            ctag_q.push_back(tg);
          end
          f++;
        end
      end
    end
  end

  initial begin : dec_compare
    logic [c_dbits-1:0] d;
    tag_t               tg;
    status_t            st;
    int                 idx;
    d          = '0;
    tg         = '0;
    st         = '0;
    idx        = 0;
    dec_frames = 0;
    forever begin
      @(posedge iclk);
      if (!ireset && iclkena && dec_out.val) begin
        if (dec_out.sop) begin
          idx = 0;
          tg  = dec_out_tag;
          st  = dec_status;
        end
        if (idx < c_dbits) d[idx] = dec_out.dat;
        idx++;
        if (dec_out.eop) begin
          if (dec_frames >= c_frames) begin
            $display("ERROR: decoder sent more frames than were driven");
            fail_cnt++;
          end
          else begin
            if (dexp_nerr[dec_frames] < 2) begin // double error data is junk
              check_word($sformatf("dec_data frame %0d", dec_frames),
                         c_nbits'(orig_data[dec_frames]), c_nbits'(d));
            end
            check_tag($sformatf("dec_tag frame %0d", dec_frames), orig_tag[dec_frames], tg);
            check_status($sformatf("dec_status frame %0d", dec_frames),
                         predict_status(dexp_nerr[dec_frames]), st);
          end
          dec_frames++;
        end
      end
    end
  end

  initial begin : watchdog
    #(c_period * (3 + 2 * c_frames * (c_nbits + c_dbits + 8) * c_gap));
    $display("ERROR: timeout, frames did not complete in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: hamming.f
+incdir+hdl
hdl/hamming_code_pkg.sv
hdl/hamming_stream_pkg.sv
hdl/hamming_enc.sv
hdl/hamming_dec.sv
hdl/hamming_codec.sv
tests/hamming_checker.sv
tests/hamming_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := hamming_tb
FILELIST  := hamming.f
RUNFLAGS  := +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST)) hdl/hamming_macros.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
